// File: rtl/tiny900_alu.sv
/*
 * tiny900 ALU
 * size-aware move, add and add with carry, carry flag register
 */
`timescale 1ns/1ps

module tiny900_alu (
    input  logic                  clk,
    input  logic                  rst,
    input  tiny900_pkg::alu_req_t req,
    output tiny900_pkg::word_t    result
);
    tiny900_pkg::word_t mask;
    logic [32:0]        sum;
    logic               cin;
    logic               carry_q;
    logic               carry_nx;

    always_comb begin
        cin = (req.op == tiny900_pkg::ALU_ADC) & carry_q;
        case (req.size)
            tiny900_pkg::SZ_BYTE: mask = 32'h0000_00ff;
            tiny900_pkg::SZ_WORD: mask = 32'h0000_ffff;
            default:              mask = 32'hffff_ffff;
        endcase
        sum = {1'b0, req.a & mask} + {1'b0, req.b & mask} + 33'(cin);
        case (req.size)  // carry out of the operand's top bit
            tiny900_pkg::SZ_BYTE: carry_nx = sum[8];
            tiny900_pkg::SZ_WORD: carry_nx = sum[16];
            default:              carry_nx = sum[32];
        endcase
        result = (req.op == tiny900_pkg::ALU_MOVE) ? req.b : sum[31:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            carry_q <= 1'b0;
        end else if (req.op == tiny900_pkg::ALU_ADD || req.op == tiny900_pkg::ALU_ADC) begin
            carry_q <= carry_nx;
        end
    end

endmodule

// File: rtl/tiny900_apb_cfg.sv
/*
 * tiny900 APB configuration slave
 * run control, status, program memory and register readback windows
 */
`timescale 1ns/1ps

module tiny900_apb_cfg #(
    parameter int PROG_BYTES = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  tiny900_pkg::apb_req_t apb_req,
    input  logic                  halted,
    input  logic                  illegal,
    input  tiny900_pkg::pc_t      pc,
    input  logic [1:0]            rfp,
    input  logic [7:0]            prog_rdata,
    input  tiny900_pkg::word_t    dbg_data,
    output tiny900_pkg::apb_rsp_t apb_rsp,
    output logic                  start,
    output logic                  prog_we,
    output tiny900_pkg::pc_t      prog_addr,
    output logic [7:0]            prog_wdata,
    output tiny900_pkg::reg_idx_t dbg_idx
);
    localparam logic [11:0] A_CTRL   = 12'h000;
    localparam logic [11:0] A_STATUS = 12'h004;
    localparam logic [11:0] A_RFP    = 12'h008;

    logic               setup, access;
    logic               sel_ctrl, sel_status, sel_rfp, sel_prog, sel_reg;
    logic               mapped, wr_blocked;
    tiny900_pkg::word_t rdata_nx;
    tiny900_pkg::word_t prdata_q;

    assign setup  = apb_req.psel & ~apb_req.penable;
    assign access = apb_req.psel & apb_req.penable;

    assign sel_ctrl   = apb_req.paddr == A_CTRL;
    assign sel_status = apb_req.paddr == A_STATUS;
    assign sel_rfp    = apb_req.paddr == A_RFP;
    assign sel_prog   = apb_req.paddr[11:8] == 4'h1 && apb_req.paddr[1:0] == 2'b00
                        && int'(apb_req.paddr[7:2]) < PROG_BYTES;
    assign sel_reg    = apb_req.paddr[11:6] == 6'b0010_00 && apb_req.paddr[1:0] == 2'b00;

    assign mapped     = sel_ctrl | sel_status | sel_rfp | sel_prog | sel_reg;
    assign wr_blocked = sel_prog & apb_req.pwrite & ~halted;  // core is running

    assign prog_addr  = tiny900_pkg::pc_t'(apb_req.paddr[7:2]);
    assign prog_wdata = apb_req.pwdata[7:0];
    assign prog_we    = access & apb_req.pwrite & sel_prog & halted;
    assign dbg_idx    = apb_req.paddr[5:2];
    assign start      = access & apb_req.pwrite & sel_ctrl & apb_req.pwdata[0];

    always_comb begin
        rdata_nx = '0;
        if (sel_ctrl) begin
            rdata_nx[0] = ~halted;   // busy
        end else if (sel_status) begin
            rdata_nx = {16'd0, pc, 6'd0, illegal, halted};
        end else if (sel_rfp) begin
            rdata_nx = {30'd0, rfp};
        end else if (sel_prog) begin
            rdata_nx = {24'd0, prog_rdata};
        end else if (sel_reg) begin
            rdata_nx = dbg_data;
        end
    end

    // sampled in the setup cycle, presented in the access cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prdata_q <= '0;
        end else if (setup & ~apb_req.pwrite) begin
            prdata_q <= rdata_nx;
        end
    end

    assign apb_rsp = '{
        prdata:  prdata_q,
        pready:  1'b1,
        pslverr: access & (~mapped | wr_blocked)
    };

endmodule

// File: rtl/tiny900_ctrl.sv
/*
 * tiny900 opcode decoder
 * phase machine driving the ALU, register writes, rfp and bytes consumed
 */
`timescale 1ns/1ps

module tiny900_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  tiny900_pkg::word_t    op_win,
    input  tiny900_pkg::word_t    rd_a,
    input  tiny900_pkg::word_t    rd_b,
    output logic [1:0]            fetched,
    output tiny900_pkg::alu_req_t alu_req,
    output tiny900_pkg::reg_wr_t  wr,
    output logic [1:0]            src_a,
    output logic [1:0]            src_b,
    output logic                  inc_rfp,
    output logic                  dec_rfp,
    output logic                  halted,
    output logic                  illegal
);
    tiny900_pkg::phase_e phase, nx_phase;
    tiny900_pkg::size_t  size_q, nx_size;
    logic [1:0]          dst_q, nx_dst;
    logic [7:0]          imm_lo, nx_imm_lo;
    logic                nx_illegal;
    logic                bad_op;
    logic [7:0]          op;

    assign op     = op_win[7:0];
    assign halted = phase == tiny900_pkg::HALTED;
    assign src_a  = dst_q;     // R from the prefix
    assign src_b  = op[1:0];   // r from the second byte

    always_comb begin
        nx_phase   = phase;
        nx_size    = size_q;
        nx_dst     = dst_q;
        nx_imm_lo  = imm_lo;
        nx_illegal = illegal;
        bad_op     = 1'b0;
        fetched    = 2'd0;
        inc_rfp    = 1'b0;
        dec_rfp    = 1'b0;
        alu_req    = '{op: tiny900_pkg::ALU_MOVE, size: size_q, a: rd_a, b: rd_b};
        wr         = '{we: 1'b0, size: size_q, dst: dst_q, data: '0};
        case (phase)
            tiny900_pkg::FETCH: begin
                casez (op)
                    tiny900_pkg::OP_NOP: begin
                        fetched = 2'd1;
                    end
                    tiny900_pkg::OP_HALT: begin
                        fetched  = 2'd1;
                        nx_phase = tiny900_pkg::HALTED;
                    end
                    tiny900_pkg::OP_INCF: begin
                        fetched = 2'd1;
                        inc_rfp = 1'b1;
                    end
                    tiny900_pkg::OP_DECF: begin
                        fetched = 2'd1;
                        dec_rfp = 1'b1;
                    end
                    8'b0010_00??, 8'b0011_00??, 8'b0100_00??: begin  // LD R,#
                        nx_size = tiny900_pkg::size_t'(op[6:4] - 3'd2);
                        nx_dst  = op[1:0];
                        fetched = 2'd2;
                        if (op[6:4] == 3'd2) begin
                            alu_req.size = tiny900_pkg::SZ_BYTE;
                            alu_req.b    = {24'd0, op_win[15:8]};
                            wr.we        = 1'b1;
                            wr.size      = tiny900_pkg::SZ_BYTE;
                            wr.dst       = op[1:0];
                        end else begin
                            // low byte now, the rest next cycle
                            nx_imm_lo = op_win[15:8];
                            nx_phase  = tiny900_pkg::FILL_IMM;
                        end
                    end
                    8'b11??_10??: begin
                        if (op[5:4] == 2'b11) begin
                            bad_op = 1'b1;            // no such size
                        end else begin
                            nx_size  = op[5:4];
                            nx_dst   = op[1:0];
                            fetched  = 2'd1;
                            nx_phase = tiny900_pkg::EXEC;
                        end
                    end
                    default: bad_op = 1'b1;
                endcase
            end
            tiny900_pkg::EXEC: begin
                nx_phase = tiny900_pkg::FETCH;
                fetched  = 2'd1;
                wr.we    = 1'b1;
                case (op[7:2])
                    tiny900_pkg::OP2_LD:  alu_req.op = tiny900_pkg::ALU_MOVE;
                    tiny900_pkg::OP2_ADD: alu_req.op = tiny900_pkg::ALU_ADD;
                    tiny900_pkg::OP2_ADC: alu_req.op = tiny900_pkg::ALU_ADC;
                    default:              bad_op     = 1'b1;
                endcase
            end
            tiny900_pkg::FILL_IMM: begin
                // pending write goes out once the immediate is whole
                nx_phase = tiny900_pkg::FETCH;
                wr.we    = 1'b1;
                if (size_q == tiny900_pkg::SZ_WORD) begin
                    alu_req.b = {16'd0, op_win[7:0], imm_lo};
                    fetched   = 2'd1;
                end else begin
                    alu_req.b = {op_win[23:0], imm_lo};
                    fetched   = 2'd3;
                end
            end
            default: ;  // halted, wait for start
        endcase
        if (bad_op) begin
            fetched    = 2'd0;    // pc stays on the bad byte
            wr.we      = 1'b0;
            alu_req.op = tiny900_pkg::ALU_MOVE;
            nx_phase   = tiny900_pkg::HALTED;
            nx_illegal = 1'b1;
        end
        if (start) begin
            nx_phase   = tiny900_pkg::FETCH;
            nx_illegal = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= tiny900_pkg::HALTED;
            size_q  <= tiny900_pkg::SZ_BYTE;
            dst_q   <= '0;
            illegal <= 1'b0;
        end else begin
            phase   <= nx_phase;
            size_q  <= nx_size;
            dst_q   <= nx_dst;
            illegal <= nx_illegal;
        end
    end

    always_ff @(posedge clk) begin
        imm_lo <= nx_imm_lo;
    end

endmodule

// File: rtl/tiny900_fetch.sv
/*
 * tiny900 fetch unit
 * program byte memory, pc and the 4-byte opcode window
 */
`timescale 1ns/1ps

module tiny900_fetch #(
    parameter int PROG_BYTES = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [1:0]         fetched,
    input  logic               prog_we,
    input  tiny900_pkg::pc_t   prog_addr,
    input  logic [7:0]         prog_wdata,
    output logic [7:0]         prog_rdata,
    output tiny900_pkg::word_t op_win,
    output tiny900_pkg::pc_t   pc
);
    localparam int AW = $clog2(PROG_BYTES);
    localparam tiny900_pkg::pc_t PC_MASK = tiny900_pkg::pc_t'(PROG_BYTES - 1);

    logic [7:0] mem [PROG_BYTES];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr[AW-1:0]] <= prog_wdata;
        end
    end

    assign prog_rdata = mem[prog_addr[AW-1:0]];

    // bytes pc..pc+3, lowest byte is the opcode
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            op_win[8*i +: 8] = mem[(AW)'(pc + tiny900_pkg::pc_t'(i))];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (start) begin
            pc <= '0;
        end else begin
            pc <= (pc + tiny900_pkg::pc_t'(fetched)) & PC_MASK;  // wraps at PROG_BYTES
        end
    end

endmodule

// File: rtl/tiny900_pkg.sv
/*
 * tiny900 shared definitions
 * data types, bus structs, opcode and ALU constants, decoder phases
 */
package tiny900_pkg;

    typedef logic [31:0] word_t;     // register and immediate data
    typedef logic [7:0]  pc_t;       // program byte address
    typedef logic [3:0]  reg_idx_t;  // {bank, reg}
    typedef logic [1:0]  size_t;
    typedef logic [1:0]  alu_op_t;

    localparam size_t SZ_BYTE = 2'd0;
    localparam size_t SZ_WORD = 2'd1;
    localparam size_t SZ_LONG = 2'd2;

    localparam alu_op_t ALU_MOVE = 2'd0;
    localparam alu_op_t ALU_ADD  = 2'd1;
    localparam alu_op_t ALU_ADC  = 2'd2;

    // single byte opcodes
    localparam logic [7:0] OP_NOP  = 8'h00;
    localparam logic [7:0] OP_HALT = 8'h05;
    localparam logic [7:0] OP_INCF = 8'h0C;
    localparam logic [7:0] OP_DECF = 8'h0D;

    // second byte after a 11zz_10RR prefix, upper six bits
    localparam logic [5:0] OP2_LD  = 6'b1000_10;
    localparam logic [5:0] OP2_ADD = 6'b1000_00;
    localparam logic [5:0] OP2_ADC = 6'b1001_00;

    typedef enum logic [1:0] {FETCH, EXEC, FILL_IMM, HALTED} phase_e;

    typedef struct packed {
        alu_op_t op;
        size_t   size;
        word_t   a;
        word_t   b;
    } alu_req_t;

    typedef struct packed {
        logic       we;
        size_t      size;
        logic [1:0] dst;   // register within the current bank
        word_t      data;
    } reg_wr_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        word_t       pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

// File: rtl/tiny900_regs.sv
/*
 * tiny900 register file
 * four banks of four 32-bit registers, rfp and sized writes
 */
`timescale 1ns/1ps

module tiny900_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  tiny900_pkg::reg_wr_t  wr,
    input  logic                  inc_rfp,
    input  logic                  dec_rfp,
    input  logic [1:0]            src_a,
    input  logic [1:0]            src_b,
    input  tiny900_pkg::reg_idx_t dbg_idx,
    output tiny900_pkg::word_t    rd_a,
    output tiny900_pkg::word_t    rd_b,
    output tiny900_pkg::word_t    dbg_data,
    output logic [1:0]            rfp
);
    tiny900_pkg::word_t    regs_q [16];
    tiny900_pkg::reg_idx_t wr_idx;

    assign wr_idx = {rfp, wr.dst};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr.we) begin
            // upper bits survive a short write
            case (wr.size)
                tiny900_pkg::SZ_BYTE: regs_q[wr_idx][7:0]  <= wr.data[7:0];
                tiny900_pkg::SZ_WORD: regs_q[wr_idx][15:0] <= wr.data[15:0];
                default:              regs_q[wr_idx]       <= wr.data;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= 2'd0;
        end else if (start) begin
            rfp <= 2'd0;
        end else if (inc_rfp) begin
            rfp <= rfp + 2'd1;   // modulo 4
        end else if (dec_rfp) begin
            rfp <= rfp - 2'd1;
        end
    end

    assign rd_a     = regs_q[{rfp, src_a}];
    assign rd_b     = regs_q[{rfp, src_b}];
    assign dbg_data = regs_q[dbg_idx];   // absolute index, ignores rfp

endmodule

// File: rtl/tiny900_top.sv
/*
 * tiny900 top level
 * core and APB configuration block
 */
`timescale 1ns/1ps

module tiny900_top #(
    parameter int PROG_BYTES = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  tiny900_pkg::apb_req_t apb_req,
    output tiny900_pkg::apb_rsp_t apb_rsp
);
    logic                  start, prog_we;
    tiny900_pkg::pc_t      prog_addr, pc;
    logic [7:0]            prog_wdata, prog_rdata;
    tiny900_pkg::reg_idx_t dbg_idx;
    tiny900_pkg::word_t    op_win, rd_a, rd_b, dbg_data, alu_result;
    logic [1:0]            fetched, src_a, src_b, rfp;
    tiny900_pkg::alu_req_t alu_req;
    tiny900_pkg::reg_wr_t  wr_ctl, wr;
    logic                  inc_rfp, dec_rfp, halted, illegal;

    // write data comes from the ALU
    assign wr = '{we: wr_ctl.we, size: wr_ctl.size, dst: wr_ctl.dst, data: alu_result};

    tiny900_apb_cfg #(.PROG_BYTES(PROG_BYTES)) u_cfg (
        .clk, .rst, .apb_req, .halted, .illegal, .pc, .rfp, .prog_rdata, .dbg_data,
        .apb_rsp, .start, .prog_we, .prog_addr, .prog_wdata, .dbg_idx
    );

    tiny900_fetch #(.PROG_BYTES(PROG_BYTES)) u_fetch (
        .clk, .rst, .start, .fetched, .prog_we, .prog_addr, .prog_wdata,
        .prog_rdata, .op_win, .pc
    );

    tiny900_ctrl u_ctrl (
        .clk, .rst, .start, .op_win, .rd_a, .rd_b,
        .fetched, .alu_req, .wr(wr_ctl), .src_a, .src_b,
        .inc_rfp, .dec_rfp, .halted, .illegal
    );

    tiny900_alu u_alu (
        .clk, .rst, .req(alu_req), .result(alu_result)
    );

    tiny900_regs u_regs (
        .clk, .rst, .start, .wr, .inc_rfp, .dec_rfp, .src_a, .src_b, .dbg_idx,
        .rd_a, .rd_b, .dbg_data, .rfp
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the tiny900 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_tiny900 \
    -f vlog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_tiny900)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// File: test/tb_tiny900.sv
/*
 * tiny900 testbench
 * random programs over APB, run to halt, register readback
 */
`timescale 1ns/1ps

module tb_tiny900;
    localparam int PROG_BYTES  = 64;
    localparam int N_PROGS     = 40;
    localparam int APB_CYCLES  = 400;   // loading, polling and readback per program
    localparam int CYCLE_LIMIT = N_PROGS * (PROG_BYTES + APB_CYCLES);

    logic                  clk;
    logic                  rst;
    tiny900_pkg::apb_req_t apb_req;
    tiny900_pkg::apb_rsp_t apb_rsp;
    logic [7:0]            prog [$];
    logic [7:0]            bad_ops [4] = '{8'h01, 8'h10, 8'hff, 8'hf8};
    int                    cycles = 0;
    int                    n_assert;

    tiny900_top #(.PROG_BYTES(PROG_BYTES)) dut (.clk, .rst, .apb_req, .apb_rsp);

    tiny900_checker #(.PROG_BYTES(PROG_BYTES)) chk (.clk, .rst, .apb_req, .apb_rsp);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the core never halted", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic apb_xfer(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        #1 apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #1 apb_req.penable = 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        @(posedge clk);
        #1 apb_req = '0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, wdata, unused);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata);
        apb_xfer(1'b0, addr, '0, rdata);
    endtask

    task automatic read_state();
        logic [31:0] d;
        apb_read(12'h004, d);
        apb_read(12'h008, d);
        for (int i = 0; i < 16; i++) begin
            apb_read(12'h200 + 12'(4 * i), d);
        end
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            apb_write(12'h100 + 12'(4 * i), {24'd0, prog[i]});
        end
    endtask

    task automatic wait_halt();
        logic [31:0] d;
        do begin
            apb_read(12'h004, d);
        end while (!d[0]);
    endtask

    // kinds 0 immediates only, 1 adds ALU ops, 2 adds INCF/DECF
    task automatic make_program(input int kinds, input int n, input logic [7:0] last);
        int          pick;
        logic [1:0]  sz;
        logic [7:0]  op2 [3] = '{8'h88, 8'h80, 8'h90};   // LD, ADD, ADC
        prog.delete();
        repeat (n) begin
            pick = $urandom_range(kinds, 0);
            sz   = 2'($urandom_range(2, 0));
            if (pick == 0) begin
                prog.push_back(8'h20 + 8'(16 * sz) + 8'($urandom_range(3, 0)));
                repeat (1 << sz) prog.push_back(8'($urandom_range(255, 0)));
            end else if (pick == 1) begin
                prog.push_back(8'hC8 | {2'b00, sz, 4'd0} | 8'($urandom_range(3, 0)));
                prog.push_back(op2[$urandom_range(2, 0)] | 8'($urandom_range(3, 0)));
            end else begin
                prog.push_back($urandom_range(1, 0) != 0 ? 8'h0C : 8'h0D);
            end
        end
        prog.push_back(last);
    endtask

    task automatic run_program();
        load_program();
        apb_write(12'h000, 32'd1);
        wait_halt();
        read_state();
    endtask

    initial begin
        logic [31:0] d;
        apb_req = '0;
        rst     = 1'b1;
        void'($urandom(69));
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        chk.begin_test("reset_state");
        read_state();
        chk.end_test();

        chk.begin_test("program_readback");
        for (int i = 0; i < PROG_BYTES; i++) begin
            apb_write(12'h100 + 12'(4 * i), 32'($urandom_range(255, 0)));
        end
        for (int i = 0; i < PROG_BYTES; i++) begin
            apb_read(12'h100 + 12'(4 * i), d);
        end
        prog.delete();
        repeat (40) prog.push_back(8'h00);
        prog.push_back(8'h05);
        load_program();
        apb_write(12'h000, 32'd1);
        apb_write(12'h100 + 12'(4 * 50), 32'h5a);   // refused while running
        wait_halt();
        apb_read(12'h100 + 12'(4 * 50), d);
        chk.end_test();

        chk.begin_test("ld_immediate");
        repeat (10) begin
            make_program(0, 8, 8'h05);
            run_program();
        end
        chk.end_test();

        chk.begin_test("alu_ops");
        repeat (10) begin
            make_program(1, 10, 8'h05);
            run_program();
        end
        chk.end_test();

        chk.begin_test("bank_switch");
        repeat (6) begin
            make_program(2, 12, 8'h05);
            run_program();
        end
        chk.end_test();

        chk.begin_test("illegal_opcode");
        repeat (3) begin
            make_program(1, 4, bad_ops[$urandom_range(3, 0)]);
            run_program();
        end
        apb_read(12'h7f0, d);
        apb_write(12'h00c, 32'd1);
        chk.end_test();

        n_assert = dut.props.n_fail;
        $display("%0d tests run, %0d passed, %0d failed, %0d assertion failures",
                 chk.tests, chk.tests - chk.failed_tests, chk.failed_tests, n_assert);
        if (chk.failed_tests == 0 && n_assert == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: test/tiny900_checker.sv
/*
 * tiny900 checker
 * snoops APB traffic, runs an instruction model, compares readbacks
 */
`timescale 1ns/1ps

module tiny900_checker #(
    parameter int PROG_BYTES = 64
) (
    input logic                  clk,
    input logic                  rst,
    input tiny900_pkg::apb_req_t apb_req,
    input tiny900_pkg::apb_rsp_t apb_rsp
);
    logic [7:0]  mem_m [PROG_BYTES];
    logic [31:0] regs_m [16];
    logic [7:0]  pc_m = '0;
    logic [1:0]  rfp_m = '0;
    logic        carry_m = 1'b0;
    logic        illegal_m = 1'b0;
    logic [31:0] exp_rd = '0;
    logic [31:0] exp_mask = '0;
    int          remaining = 0;   // cycles until the core halts
    string       test_name = "none";
    int          errs = 0;
    int          tests = 0;
    int          failed_tests = 0;

    initial begin
        for (int i = 0; i < 16; i++) begin
            regs_m[i] = '0;
        end
        for (int i = 0; i < PROG_BYTES; i++) begin
            mem_m[i] = '0;
        end
    end

    function automatic logic [31:0] size_mask(input logic [1:0] sz);
        return (sz == 2'd0) ? 32'h0000_00ff : (sz == 2'd1) ? 32'h0000_ffff : 32'hffff_ffff;
    endfunction

    function automatic logic [7:0] byte_at(input logic [7:0] addr);
        return mem_m[int'(addr) % PROG_BYTES];
    endfunction

    function automatic logic is_prog(input logic [11:0] a);
        return a[11:8] == 4'h1 && a[1:0] == 2'b00 && int'(a[7:2]) < PROG_BYTES;
    endfunction

    function automatic logic is_mapped(input logic [11:0] a);
        return a == 12'h000 || a == 12'h004 || a == 12'h008 || is_prog(a)
            || (a[11:6] == 6'b0010_00 && a[1:0] == 2'b00);
    endfunction

    task automatic write_reg(input logic [3:0] idx, input logic [1:0] sz, input logic [31:0] v);
        logic [31:0] m;
        m = size_mask(sz);
        regs_m[idx] = (regs_m[idx] & ~m) | (v & m);   // upper bits kept
    endtask

    // runs the program from pc 0, returns the cycle count to halt
    task automatic run_model(output int cyc);
        logic [7:0]  op;
        logic [7:0]  op2;
        logic [1:0]  sz;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] s;
        int          n;
        bit          done;
        pc_m      = '0;
        rfp_m     = '0;
        illegal_m = 1'b0;
        cyc       = 0;
        done      = 0;
        while (!done && cyc < 500) begin
            op = byte_at(pc_m);
            cyc++;
            if (op == 8'h00) begin
                pc_m = pc_m + 8'd1;
            end else if (op == 8'h05) begin
                pc_m = pc_m + 8'd1;
                done = 1;
            end else if (op == 8'h0C || op == 8'h0D) begin
                pc_m  = pc_m + 8'd1;
                rfp_m = (op == 8'h0C) ? rfp_m + 2'd1 : rfp_m - 2'd1;
            end else if (op[3:2] == 2'b00 && (op[7:4] == 4'h2 || op[7:4] == 4'h3
                                              || op[7:4] == 4'h4)) begin
                sz  = 2'(op[6:4] - 3'd2);
                n   = 1 << sz;
                imm = '0;
                for (int k = 0; k < n; k++) begin
                    imm[8*k +: 8] = byte_at(pc_m + 8'(1 + k));
                end
                write_reg({rfp_m, op[1:0]}, sz, imm);
                pc_m = pc_m + 8'(1 + n);
                if (sz != 2'd0) cyc++;
            end else if (op[7:6] == 2'b11 && op[3:2] == 2'b10 && op[5:4] != 2'b11) begin
                op2  = byte_at(pc_m + 8'd1);
                sz   = op[5:4];
                cyc++;
                pc_m = pc_m + 8'd1;
                a    = regs_m[{rfp_m, op[1:0]}];
                b    = regs_m[{rfp_m, op2[1:0]}];
                if (op2[7:2] == 6'b1000_10) begin
                    write_reg({rfp_m, op[1:0]}, sz, b);
                end else if (op2[7:2] == 6'b1000_00 || op2[7:2] == 6'b1001_00) begin
                    s = {1'b0, a & size_mask(sz)} + {1'b0, b & size_mask(sz)}
                        + 33'(op2[4] & carry_m);
                    carry_m = s[8 << sz];
                    write_reg({rfp_m, op[1:0]}, sz, s[31:0]);
                end else begin
                    illegal_m = 1'b1;   // pc stays on the second byte
                    done      = 1;
                end
                if (!done) pc_m = pc_m + 8'd1;
            end else begin
                illegal_m = 1'b1;
                done      = 1;
            end
            pc_m = pc_m & 8'(PROG_BYTES - 1);
        end
    endtask

    task automatic predict(input logic [11:0] a);
        exp_mask = '1;
        exp_rd   = '0;
        if (a == 12'h004) begin
            if (remaining != 0) exp_mask = 32'h3;   // pc moving, only flags known
            else exp_rd = {16'd0, pc_m, 6'd0, illegal_m, 1'b1};
        end else if (a == 12'h008) begin
            exp_rd = {30'd0, rfp_m};
        end else if (is_prog(a)) begin
            exp_rd = {24'd0, mem_m[int'(a[7:2])]};
        end else begin
            exp_rd = regs_m[a[5:2]];
        end
    endtask

    task automatic compare(input string what, input logic [31:0] e, input logic [31:0] act);
        if (e !== act) begin
            errs++;
            $display("FAIL %s: %s expected %h actual %h", test_name, what, e, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errs      = 0;
    endtask

    task automatic end_test();
        tests++;
        if (errs != 0) begin
            failed_tests++;
            $display("%s: test failed with %0d mismatches", test_name, errs);
        end else begin
            $display("%s: test passed", test_name);
        end
    endtask

    task automatic check_access();
        logic [11:0] a;
        logic        exp_err;
        int          cyc;
        a       = apb_req.paddr;
        exp_err = !is_mapped(a) || (is_prog(a) && apb_req.pwrite && remaining != 0);
        compare($sformatf("pslverr at %h", a), 32'(exp_err), 32'(apb_rsp.pslverr));
        if (!apb_req.pwrite && is_mapped(a) && a != 12'h000) begin
            compare($sformatf("read at %h", a), exp_rd & exp_mask, apb_rsp.prdata & exp_mask);
        end
        if (apb_req.pwrite && is_prog(a) && !exp_err) begin
            mem_m[int'(a[7:2])] = apb_req.pwdata[7:0];
        end
        if (apb_req.pwrite && a == 12'h000 && apb_req.pwdata[0]) begin
            run_model(cyc);
            remaining = cyc + 1;
        end
    endtask

    // setup phase predicts, access phase compares
    always @(negedge clk) begin
        if (!rst && apb_req.psel) begin
            if (!apb_req.penable) predict(apb_req.paddr);
            else check_access();
        end
    end

    always @(posedge clk) begin
        if (remaining > 0) remaining = remaining - 1;
    end

endmodule

// File: test/tiny900_properties.sv
/*
 * tiny900 bound properties
 * APB handshake rules and decoder output checks
 */
`timescale 1ns/1ps

module tiny900_properties (
    input logic                  clk,
    input logic                  rst,
    input tiny900_pkg::apb_req_t apb_req,
    input tiny900_pkg::apb_rsp_t apb_rsp,
    input logic [1:0]            fetched,
    input logic                  halted,
    input logic                  wr_we
);
    int n_fail = 0;   // read by the testbench at the end

    a_pready: assert property (@(posedge clk) disable iff (rst) apb_rsp.pready)
        else begin
            $error("pready dropped low");
            n_fail++;
        end

    // access phase needs a setup cycle just before it
    a_setup: assert property (@(posedge clk) disable iff (rst)
        $rose(apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
        else begin
            $error("penable rose without a setup cycle");
            n_fail++;
        end

    a_fetched: assert property (@(posedge clk) disable iff (rst) fetched <= 2'd3)
        else begin
            $error("fetched out of range");
            n_fail++;
        end

    a_we_halted: assert property (@(posedge clk) disable iff (rst) halted |-> !wr_we)
        else begin
            $error("register write while halted");
            n_fail++;
        end

endmodule

bind tiny900_top tiny900_properties props (
    .clk, .rst, .apb_req, .apb_rsp, .fetched, .halted, .wr_we(wr.we)
);

// File: vlog.f
rtl/tiny900_pkg.sv
rtl/tiny900_fetch.sv
rtl/tiny900_ctrl.sv
rtl/tiny900_alu.sv
rtl/tiny900_regs.sv
rtl/tiny900_apb_cfg.sv
rtl/tiny900_top.sv
test/tiny900_properties.sv
test/tiny900_checker.sv
test/tb_tiny900.sv
